// File: tlb_pkg.sv
// tlb shared definitions
package tlb_pkg;

  // ==========================================================
  // geometry
  // ==========================================================
  localparam int TLB_WAYS  = 4;         // way 3 holds pinned entries
  localparam int SET_BITS  = 10;        // set index from vadr[21:12]
  localparam int PAGE_BITS = 12;        // 4 KB pages
  localparam int ENTRY_W   = 64;        // one ram word per entry

  localparam logic [3:0] ACR_FULL = 4'b1111;  // c r w x, translation off

  // ==========================================================
  // entry layout, msb first
  // ==========================================================
  typedef struct packed {
    logic [17:0] rsvd;    // [63:46] spare, written as zero
    logic [7:0]  asid;    // [45:38] address space id
    logic        g;       // global, asid ignored
    logic        d;       // dirty
    logic        a;       // accessed
    logic        u;       // user page
    logic        c;       // cacheable
    logic        r;       // read
    logic        w;       // write
    logic        x;       // execute
    logic [9:0]  vpn;     // [29:20] tag, vadr[31:22]
    logic [19:0] ppn;     // [19:0] physical page number
  } tlb_entry_t;

  // boot sequencer states
  typedef enum logic {
    boot_fill = 1'b0,     // writing pinned pages into way 3
    boot_run  = 1'b1      // fill done, tlb ready
  } boot_state_e;

endpackage

// File: tlb_ram.sv
// tlb way ram
`timescale 1ns/1ps

module tlb_ram (
  input  logic                         clk_g,
  // port a, software and boot fill
  input  logic                         ena_i,
  input  logic                         wea_i,
  input  logic [tlb_pkg::SET_BITS-1:0] addra_i,
  input  logic [tlb_pkg::ENTRY_W-1:0]  dina_i,
  output logic [tlb_pkg::ENTRY_W-1:0]  douta_o,
  // port b, lookup and a/d write-back
  input  logic                         enb_i,
  input  logic                         web_i,
  input  logic [tlb_pkg::SET_BITS-1:0] addrb_i,
  input  logic [tlb_pkg::ENTRY_W-1:0]  dinb_i,
  output logic [tlb_pkg::ENTRY_W-1:0]  doutb_o
);

  localparam int DEPTH = 2 ** tlb_pkg::SET_BITS;  // 1024 sets

  logic [tlb_pkg::ENTRY_W-1:0] mem [DEPTH];

  // all zero at power up, so an unwritten set never matches a live tag
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // writes ignore the enables; port a last so software wins a collision
  always_ff @(posedge clk_g) begin
    if (web_i) mem[addrb_i] <= dinb_i;
    if (wea_i) mem[addra_i] <= dina_i;
  end

  always_ff @(posedge clk_g) begin
    if (ena_i) douta_o <= mem[addra_i];   // read first, one cycle
  end

  always_ff @(posedge clk_g) begin
    if (enb_i) doutb_o <= mem[addrb_i];   // holds while lookup disabled
  end

endmodule

// File: tlb_boot_fill.sv
// tlb boot fill sequencer
`timescale 1ns/1ps

module tlb_boot_fill #(
  parameter int BOOT_PAGES = 64           // pinned pages, counted down from set 1023
) (
  input  logic                         clk_g,
  input  logic                         rst_i,
  output logic                         boot_busy_o,
  output logic                         boot_we_o,
  output logic [tlb_pkg::SET_BITS-1:0] boot_set_o,
  output tlb_pkg::tlb_entry_t          boot_dat_o,
  output logic                         rdy_o
);

  localparam int SB    = tlb_pkg::SET_BITS;
  localparam int CNT_W = $clog2(BOOT_PAGES + 1);

  tlb_pkg::boot_state_e state;
  logic [CNT_W-1:0]     pg_cnt;           // pages issued so far
  logic [SB-1:0]        fill_set;
  tlb_pkg::tlb_entry_t  fill_ent;

  assign fill_set = ~SB'(pg_cnt);         // 1023, 1022, ...

  // identity map, va == pa over the top of the address space
  always_comb begin
    fill_ent      = '0;                   // asid 0, user clear
    fill_ent.g    = 1'b1;
    fill_ent.d    = 1'b1;
    fill_ent.a    = 1'b1;
    fill_ent.c    = 1'b1;
    fill_ent.r    = 1'b1;
    fill_ent.w    = 1'b1;
    fill_ent.x    = 1'b1;
    fill_ent.vpn  = '1;
    fill_ent.ppn  = {{SB{1'b1}}, fill_set};
  end

  // ==========================================================
  // sequencer
  // ==========================================================
  always_ff @(posedge clk_g) begin
    if (rst_i) begin
      state       <= tlb_pkg::boot_fill;
      pg_cnt      <= '0;
      boot_we_o   <= 1'b0;
      boot_busy_o <= 1'b1;                // holds port a from reset on
    end else begin
      case (state)
        tlb_pkg::boot_fill: begin
          if (pg_cnt == CNT_W'(BOOT_PAGES)) begin
            state       <= tlb_pkg::boot_run;
            boot_we_o   <= 1'b0;
            boot_busy_o <= 1'b0;          // last write lands on this edge
          end else begin
            boot_we_o <= 1'b1;            // one page per cycle
            pg_cnt    <= pg_cnt + 1'b1;
          end
        end
        tlb_pkg::boot_run: begin
          boot_we_o   <= 1'b0;
          boot_busy_o <= 1'b0;
        end
      endcase
    end
  end

  // set and entry travel with boot_we_o
  always_ff @(posedge clk_g) begin
    boot_set_o <= fill_set;
    boot_dat_o <= fill_ent;
  end

  assign rdy_o = ~boot_busy_o;

endmodule

// File: tlb_sw_port.sv
// tlb software port
`timescale 1ns/1ps

module tlb_sw_port (
  input  logic                                               clk_g,
  input  logic                                               rst_i,
  // processor side
  input  logic                                               tlben_i,
  input  logic                                               wrtlb_i,
  input  logic [15:0]                                        tlbadr_i,
  input  logic [tlb_pkg::ENTRY_W-1:0]                        tlbdat_i,
  output logic [tlb_pkg::ENTRY_W-1:0]                        tlbdat_o,
  // boot fill override
  input  logic                                               boot_busy_i,
  input  logic                                               boot_we_i,
  input  logic [tlb_pkg::SET_BITS-1:0]                       boot_set_i,
  input  tlb_pkg::tlb_entry_t                                boot_dat_i,
  // ram port a, shared by all ways
  output logic                                               ram_ena_o,
  output logic [tlb_pkg::TLB_WAYS-1:0]                       ram_wea_o,
  output logic [tlb_pkg::SET_BITS-1:0]                       ram_addra_o,
  output logic [tlb_pkg::ENTRY_W-1:0]                        ram_dina_o,
  input  logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::ENTRY_W-1:0] ram_douta_i
);

  localparam int NW      = tlb_pkg::TLB_WAYS;
  localparam int WB      = $clog2(NW);
  localparam int PIN_WAY = NW - 1;        // never picked at random

  logic [WB-1:0] rand_way;
  logic [NW-1:0] sw_we;
  logic [WB-1:0] way_sel;

  assign way_sel = tlbadr_i[10 +: WB];    // tlbadr[11:10]

  // free running 0,1,2 while no write is pending
  always_ff @(posedge clk_g) begin
    if (rst_i) rand_way <= '0;
    else if (!wrtlb_i) rand_way <= (rand_way == WB'(NW - 2)) ? '0 : rand_way + 1'b1;
  end

  // tlbadr[15] picks a random way among the unpinned ones
  always_comb begin
    for (int i = 0; i < NW; i++) begin
      if (tlbadr_i[15]) sw_we[i] = (i != PIN_WAY) && (rand_way == WB'(i));
      else sw_we[i] = (way_sel == WB'(i));
    end
    sw_we = sw_we & {NW{tlben_i & wrtlb_i}};
  end

  // boot owns port a until the fill is done, way 3 only
  assign ram_ena_o   = tlben_i | boot_busy_i;
  assign ram_wea_o   = boot_busy_i ? {boot_we_i, {(NW - 1){1'b0}}} : sw_we;
  assign ram_addra_o = boot_busy_i ? boot_set_i : tlbadr_i[tlb_pkg::SET_BITS-1:0];
  assign ram_dina_o  = boot_busy_i ? boot_dat_i : tlbdat_i;

  assign tlbdat_o = ram_douta_i[way_sel];  // readback, address held one cycle

endmodule

// File: tlb_lookup.sv
// tlb lookup and a/d update
`timescale 1ns/1ps

module tlb_lookup #(
  parameter int              AWID       = 32,
  parameter logic [AWID-1:0] RESET_PADR = 32'hFFFC_0000
) (
  input  logic                                               clk_g,
  input  logic                                               rst_i,
  input  logic [7:0]                                         asid_i,
  input  logic                                               xlaten_i,
  input  logic                                               we_i,
  input  logic                                               iacc_i,
  input  logic                                               dacc_i,
  input  logic                                               next_i,
  input  logic [AWID-1:0]                                    ladr_i,
  input  logic [AWID-1:0]                                    iadr_i,
  // ram port b
  output logic                                               ram_enb_o,
  output logic [tlb_pkg::SET_BITS-1:0]                       ram_addrb_o,
  output logic [tlb_pkg::TLB_WAYS-1:0]                       ram_web_o,
  output logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::ENTRY_W-1:0] ram_dinb_o,
  input  logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::ENTRY_W-1:0] ram_doutb_i,
  // translation result
  output logic [AWID-1:0]                                    padr_o,
  output logic [3:0]                                         acr_o,
  output logic                                               tlbmiss_o
);

  localparam int NW     = tlb_pkg::TLB_WAYS;
  localparam int PB     = tlb_pkg::PAGE_BITS;
  localparam int SB     = tlb_pkg::SET_BITS;
  localparam int VPN_W  = AWID - PB - SB;  // tag bits above the set index
  localparam int STABLE = 5;               // cycles before a miss is believed

  logic                xlat_q, pe_xlat, ne_xlat;
  logic [AWID-1:0]     ladr_q, iadr_q;
  logic                cd_ladr, cd_iadr;
  logic [STABLE-1:0]   stab_l, stab_i;     // ones shift in while address holds
  logic [AWID-1:0]     sel_adr;
  logic                sel_stable, sel_cd, any_acc, take_hit;
  tlb_pkg::tlb_entry_t ent [NW];
  logic [NW-1:0]       tag_hit, hit_1h, hit_q;
  logic                hit_any;
  tlb_pkg::tlb_entry_t hit_ent, cap_ent, wb_ent;
  logic [SB-1:0]       cap_set;
  logic                wed, wb_q;

  // ==========================================================
  // edge and change detect
  // ==========================================================
  always_ff @(posedge clk_g) begin
    if (rst_i) xlat_q <= 1'b0;
    else xlat_q <= xlaten_i;
  end
  assign pe_xlat = xlaten_i & ~xlat_q;
  assign ne_xlat = ~xlaten_i & xlat_q;

  always_ff @(posedge clk_g) begin
    ladr_q <= ladr_i;
    iadr_q <= iadr_i;
  end
  assign cd_ladr = (ladr_i != ladr_q);
  assign cd_iadr = (iadr_i != iadr_q);

  always_ff @(posedge clk_g) begin
    if (rst_i || cd_ladr) stab_l <= '0;
    else stab_l <= {stab_l[STABLE-2:0], 1'b1};
    if (rst_i || cd_iadr) stab_i <= '0;
    else stab_i <= {stab_i[STABLE-2:0], 1'b1};
  end

  assign sel_adr    = iacc_i ? iadr_i : ladr_i;           // instruction side first
  assign sel_stable = iacc_i ? stab_i[STABLE-1] : stab_l[STABLE-1];
  assign sel_cd     = iacc_i ? cd_iadr : cd_ladr;
  assign any_acc    = iacc_i | dacc_i;

  // ==========================================================
  // tag compare, way 0 has priority
  // ==========================================================
  always_comb begin
    for (int i = 0; i < NW; i++) begin
      ent[i]     = ram_doutb_i[i];
      tag_hit[i] = (ent[i].vpn == sel_adr[AWID-1 -: VPN_W]) &&
                   (ent[i].asid == asid_i || ent[i].g);
    end
    hit_1h  = '0;
    hit_ent = ent[0];
    for (int i = NW - 1; i >= 0; i--) begin
      if (tag_hit[i]) begin
        hit_1h    = '0;
        hit_1h[i] = 1'b1;
        hit_ent   = ent[i];
      end
    end
  end
  assign hit_any  = |tag_hit;
  assign take_hit = xlaten_i & any_acc & ~next_i & hit_any;

  // translation register; a burst step beats a new access
  always_ff @(posedge clk_g) begin
    if (rst_i) begin
      padr_o    <= RESET_PADR;
      acr_o     <= '0;
      tlbmiss_o <= 1'b0;
    end else if (next_i) begin
      padr_o <= padr_o + AWID'(32);       // next 32 byte beat
    end else if (any_acc) begin
      if (!xlaten_i) begin
        padr_o    <= sel_adr;             // pass through
        acr_o     <= tlb_pkg::ACR_FULL;
        tlbmiss_o <= 1'b0;
      end else if (hit_any) begin
        padr_o    <= AWID'({hit_ent.ppn, sel_adr[PB-1:0]});
        acr_o     <= {hit_ent.c, hit_ent.r, hit_ent.w, hit_ent.x};
        tlbmiss_o <= 1'b0;
      end else begin
        padr_o    <= '0;
        tlbmiss_o <= sel_stable & ~sel_cd;  // ram read has settled
      end
    end
  end

  // ==========================================================
  // accessed/dirty write-back
  // ==========================================================
  always_ff @(posedge clk_g) begin
    if (rst_i) begin
      hit_q <= '0;
      wb_q  <= 1'b0;
    end else begin
      wb_q <= ne_xlat & (|hit_q);         // one write cycle after the fall
      if (pe_xlat) hit_q <= '0;
      else if (take_hit) hit_q <= hit_1h; // only the last hit way
    end
  end

  always_ff @(posedge clk_g) begin
    wed <= we_i;
    if (take_hit) begin
      cap_ent <= hit_ent;
      cap_set <= sel_adr[PB +: SB];
    end
    if (ne_xlat) begin
      wb_ent   <= cap_ent;
      wb_ent.a <= 1'b1;
      wb_ent.d <= wed;                    // last write flag
    end
  end

  assign ram_enb_o   = xlaten_i;
  assign ram_addrb_o = wb_q ? cap_set : sel_adr[PB +: SB];
  assign ram_web_o   = hit_q & {NW{wb_q}};

  always_comb begin
    for (int i = 0; i < NW; i++) begin
      ram_dinb_o[i] = wb_ent;             // only the enabled way takes it
    end
  end

endmodule

// File: tlb.sv
// tlb top level
`timescale 1ns/1ps

module tlb #(
  parameter int              AWID       = 32,
  parameter logic [AWID-1:0] RESET_PADR = 32'hFFFC_0000,  // first pinned page
  parameter int              BOOT_PAGES = 64               // top 256 KB
) (
  input  logic                        clk_g,
  input  logic                        rst_i,
  output logic                        rdy_o,
  // lookup side
  input  logic [7:0]                  asid_i,
  input  logic                        xlaten_i,
  input  logic                        we_i,
  input  logic [AWID-1:0]             ladr_i,
  input  logic [AWID-1:0]             iadr_i,
  input  logic                        iacc_i,
  input  logic                        dacc_i,
  input  logic                        next_i,
  output logic [AWID-1:0]             padr_o,
  output logic [3:0]                  acr_o,
  output logic                        tlbmiss_o,
  // software side
  input  logic                        tlben_i,
  input  logic                        wrtlb_i,
  input  logic [15:0]                 tlbadr_i,
  input  logic [tlb_pkg::ENTRY_W-1:0] tlbdat_i,
  output logic [tlb_pkg::ENTRY_W-1:0] tlbdat_o
);

  localparam int NW = tlb_pkg::TLB_WAYS;
  localparam int SB = tlb_pkg::SET_BITS;
  localparam int EW = tlb_pkg::ENTRY_W;

  logic                boot_busy, boot_we;
  logic [SB-1:0]       boot_set;
  tlb_pkg::tlb_entry_t boot_dat;

  logic                   ram_ena, ram_enb;   // a shared, b shared
  logic [NW-1:0]          ram_wea, ram_web;
  logic [SB-1:0]          ram_addra, ram_addrb;
  logic [EW-1:0]          ram_dina;
  logic [NW-1:0][EW-1:0]  ram_douta, ram_dinb, ram_doutb;

  // ==========================================================
  // control blocks
  // ==========================================================
  tlb_boot_fill #(.BOOT_PAGES(BOOT_PAGES)) u_boot (
    .clk_g, .rst_i,
    .boot_busy_o(boot_busy), .boot_we_o(boot_we),
    .boot_set_o(boot_set),   .boot_dat_o(boot_dat),
    .rdy_o
  );

  tlb_sw_port u_sw (
    .clk_g, .rst_i,
    .tlben_i, .wrtlb_i, .tlbadr_i, .tlbdat_i, .tlbdat_o,
    .boot_busy_i(boot_busy), .boot_we_i(boot_we),
    .boot_set_i(boot_set),   .boot_dat_i(boot_dat),
    .ram_ena_o(ram_ena),     .ram_wea_o(ram_wea),
    .ram_addra_o(ram_addra), .ram_dina_o(ram_dina),
    .ram_douta_i(ram_douta)
  );

  tlb_lookup #(.AWID(AWID), .RESET_PADR(RESET_PADR)) u_look (
    .clk_g, .rst_i,
    .asid_i, .xlaten_i, .we_i, .iacc_i, .dacc_i, .next_i, .ladr_i, .iadr_i,
    .ram_enb_o(ram_enb),     .ram_addrb_o(ram_addrb),
    .ram_web_o(ram_web),     .ram_dinb_o(ram_dinb), .ram_doutb_i(ram_doutb),
    .padr_o, .acr_o, .tlbmiss_o
  );

  // one ram per way
  for (genvar w = 0; w < NW; w++) begin : g_way
    tlb_ram u_ram (
      .clk_g,
      .ena_i(ram_ena), .wea_i(ram_wea[w]), .addra_i(ram_addra),
      .dina_i(ram_dina), .douta_o(ram_douta[w]),
      .enb_i(ram_enb), .web_i(ram_web[w]), .addrb_i(ram_addrb),
      .dinb_i(ram_dinb[w]), .doutb_o(ram_doutb[w])
    );
  end

endmodule

// File: tb_clk_gen.sv
// testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0          // 250 MHz
) (
  output logic clk_o
);

  initial clk_o = 1'b0;                   // first rising edge at half a period

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: tb_tlb.sv
// tlb directed testbench
`timescale 1ns/1ps

module tb_tlb;

  localparam logic [31:0] RESET_PADR  = 32'hFFFC_0000;
  localparam int          BOOT_PAGES  = 64;
  localparam int          HOLD        = 8;      // lookup settle, 7 edges for a miss
  localparam int          WATCHDOG_NS = 20000;  // ~250 clocks of tests at 4 ns, wide margin

  logic        clk_g, rst_i, rdy_o, xlaten_i, we_i, iacc_i, dacc_i, next_i;
  logic        tlben_i, wrtlb_i, tlbmiss_o;
  logic [7:0]  asid_i;
  logic [3:0]  acr_o;
  logic [15:0] tlbadr_i;
  logic [31:0] ladr_i, iadr_i, padr_o;
  logic [63:0] tlbdat_i, tlbdat_o;

  logic [63:0] ref_mem [4][1024];         // expected ram image per way
  logic [1:0]  last_way;                  // last predicted hit
  logic [9:0]  last_set;
  logic        last_ok;                   // a hit since xlaten rose
  integer      seed = 67;

  tb_clk_gen #(.PERIOD_NS(4.0)) u_clk (.clk_o(clk_g));

  tlb #(.AWID(32), .RESET_PADR(RESET_PADR), .BOOT_PAGES(BOOT_PAGES)) dut (
    .clk_g, .rst_i, .rdy_o, .asid_i, .xlaten_i, .we_i, .ladr_i, .iadr_i, .iacc_i,
    .dacc_i, .next_i, .padr_o, .acr_o, .tlbmiss_o,
    .tlben_i, .wrtlb_i, .tlbadr_i, .tlbdat_i, .tlbdat_o
  );

  // ==========================================================
  // helpers
  // ==========================================================
  task automatic abort(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else
      abort($sformatf("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act));
  endtask

  task automatic tick(input int n);
    repeat (n) @(negedge clk_g);          // every task starts and ends on a falling edge
  endtask

  // identity page for the top 256 KB
  function automatic logic [63:0] pinned_entry(input logic [9:0] set);
    tlb_pkg::tlb_entry_t e;
    e     = '0;
    {e.g, e.d, e.a, e.c, e.r, e.w, e.x} = 7'h7F;   // user clear
    e.vpn = '1;
    e.ppn = {10'h3FF, set};
    return e;
  endfunction

  function automatic logic [63:0] random_entry(input logic [9:0] vpn, input logic [7:0] asid,
                                               input logic g);
    tlb_pkg::tlb_entry_t e;
    e      = '0;
    {e.d, e.a, e.u, e.c, e.r, e.w, e.x} = 7'($random(seed));
    e.asid = asid;
    e.g    = g;
    e.vpn  = vpn;
    e.ppn  = 20'($random(seed));
    return e;
  endfunction

  // first matching way wins, way 0 highest
  function automatic void predict(input logic [31:0] va, input logic [7:0] asid,
                                  output logic hit, output logic [1:0] way,
                                  output tlb_pkg::tlb_entry_t e);
    tlb_pkg::tlb_entry_t cand;
    hit = 1'b0;
    way = '0;
    e   = '0;
    for (int w = 3; w >= 0; w--) begin
      cand = ref_mem[w][va[21:12]];
      if (cand.vpn == va[31:22] && (cand.asid == asid || cand.g)) begin
        hit = 1'b1;
        way = 2'(w);
        e   = cand;
      end
    end
  endfunction

  task automatic sw_write(input logic [1:0] way, input logic [9:0] set, input logic rnd,
                          input logic [63:0] dat);
    tlben_i  = 1'b1;
    wrtlb_i  = 1'b1;
    tlbadr_i = {rnd, 3'b000, way, set};
    tlbdat_i = dat;
    tick(1);                              // lands on this rising edge
    tlben_i  = 1'b0;
    wrtlb_i  = 1'b0;
    if (!rnd) ref_mem[way][set] = dat;    // random way resolved by the caller
  endtask

  task automatic sw_read(input logic [1:0] way, input logic [9:0] set, output logic [63:0] dat);
    tlben_i  = 1'b1;
    tlbadr_i = {4'b0, way, set};
    tick(1);                              // one cycle readback
    dat      = tlbdat_o;
    tlben_i  = 1'b0;
  endtask

  task automatic read_check(input logic [1:0] way, input logic [9:0] set);
    logic [63:0] dat;
    sw_read(way, set, dat);
    check_eq($sformatf("tlbdat_o way %0d set %0d", way, set), ref_mem[way][set], dat);
  endtask

  // translated lookup, held until the miss filter has settled
  task automatic lookup(input logic [31:0] va, input logic [7:0] asid, input logic inst,
                        input logic we);
    tlb_pkg::tlb_entry_t e;
    logic                hit;
    logic [1:0]          way;
    logic [31:0]         pa;
    predict(va, asid, hit, way, e);
    pa     = hit ? {e.ppn, va[11:0]} : 32'h0;
    asid_i = asid;
    we_i   = we;
    if (inst) iadr_i = va;
    else ladr_i = va;
    iacc_i = inst;
    dacc_i = !inst;
    tick(HOLD);
    check_eq("padr_o", 64'(pa), 64'(padr_o));
    check_eq("tlbmiss_o", 64'(!hit), 64'(tlbmiss_o));
    if (hit) begin
      check_eq("acr_o", 64'({e.c, e.r, e.w, e.x}), 64'(acr_o));
      last_way = way;
      last_set = va[21:12];
      last_ok  = 1'b1;
    end
    iacc_i = 1'b0;
    dacc_i = 1'b0;
  endtask

  // the fall writes back the last hit with a set and d from we
  task automatic set_xlat(input logic on);
    tlb_pkg::tlb_entry_t e;
    xlaten_i = on;
    if (on) last_ok = 1'b0;               // hit flags clear on the rise
    else if (last_ok) begin
      e   = ref_mem[last_way][last_set];
      e.a = 1'b1;
      e.d = we_i;
      ref_mem[last_way][last_set] = e;
    end
    tick(3);                              // edge detect, then write-back
  endtask

  initial begin
    #WATCHDOG_NS;
    abort("watchdog expired before the tests ended");
  end

  // ==========================================================
  // directed tests
  // ==========================================================
  initial begin : main
    tlb_pkg::tlb_entry_t ent;
    logic [63:0]         dat;
    logic [9:0]          vpn [3];
    logic [9:0]          sets [3];
    logic [7:0]          asid [3];
    logic [31:0]         va, pa;
    int                  found, count;
    rst_i    = 1'b1;
    xlaten_i = 1'b0;
    we_i     = 1'b0;
    iacc_i   = 1'b0;
    dacc_i   = 1'b0;
    next_i   = 1'b0;
    asid_i   = '0;
    ladr_i   = '0;
    iadr_i   = '0;
    tlben_i  = 1'b0;
    wrtlb_i  = 1'b0;
    tlbadr_i = '0;
    tlbdat_i = '0;
    for (int w = 0; w < 4; w++)
      for (int s = 0; s < 1024; s++) ref_mem[w][s] = '0;   // rams start zeroed

    // boot fill and pinned identity pages
    tick(5);
    check_eq("rdy_o", 64'd0, 64'(rdy_o));
    check_eq("padr_o", 64'(RESET_PADR), 64'(padr_o));
    rst_i = 1'b0;
    tick(1);
    check_eq("rdy_o", 64'd0, 64'(rdy_o));
    for (int i = 0; i < BOOT_PAGES + 16 && !rdy_o; i++) tick(1);
    if (!rdy_o) abort("rdy_o never rose after the boot fill");
    for (int s = 1024 - BOOT_PAGES; s < 1024; s++) ref_mem[3][s] = pinned_entry(10'(s));
    read_check(2'd3, 10'd1023);
    read_check(2'd3, 10'(1024 - BOOT_PAGES));
    set_xlat(1'b1);
    lookup(32'hFFFF_F123, 8'h5A, 1'b0, 1'b0);
    check_eq("padr_o", 64'h0000_0000_FFFF_F123, 64'(padr_o));
    check_eq("acr_o", 64'hF, 64'(acr_o));

    // way writes, readback, asid and global matching
    for (int i = 0; i < 3; i++) begin
      vpn[i]  = 10'($random(seed)) | 10'h001;   // nonzero, unlike cleared entries
      asid[i] = 8'($random(seed)) | 8'h01;
      sets[i] = 10'(16 + 97 * i);
      sw_write(2'(i), sets[i], 1'b0, random_entry(vpn[i], asid[i], i == 2));
      read_check(2'(i), sets[i]);
      lookup({vpn[i], sets[i], 12'($random(seed))}, asid[i], 1'b0, 1'b0);
    end
    lookup({vpn[2], sets[2], 12'h0F0}, asid[2] ^ 8'h80, 1'b1, 1'b0);  // global, other asid
    lookup({vpn[0], sets[0], 12'h004}, asid[0], 1'b0, 1'b0);
    lookup({vpn[0], sets[0], 12'h008}, asid[0] ^ 8'h80, 1'b0, 1'b0);  // wrong asid
    check_eq("tlbmiss_o", 64'd1, 64'(tlbmiss_o));

    // random way write never touches way 3
    for (int w = 0; w < 4; w++) sw_write(2'(w), 10'd400, 1'b0, 64'h0);
    dat = random_entry(10'h2A5, 8'h33, 1'b0);
    sw_write(2'd0, 10'd400, 1'b1, dat);
    count = 0;
    found = 0;
    for (int w = 0; w < 3; w++) begin
      sw_read(2'(w), 10'd400, ent);
      if (ent === dat) begin
        count++;
        found = w;
      end else check_eq($sformatf("tlbdat_o way %0d set 400", w), ref_mem[w][400], ent);
    end
    check_eq("ways holding the random entry", 64'd1, 64'(count));
    read_check(2'd3, 10'd400);
    ref_mem[found][400] = dat;
    lookup({10'h2A5, 10'd400, 12'h321}, 8'h33, 1'b1, 1'b0);
    lookup({10'h2A5, 10'd400, 12'h654}, 8'h34, 1'b1, 1'b0);  // miss left high into pass through

    // translation off, pass through and burst steps
    set_xlat(1'b0);
    for (int k = 0; k < 2; k++) begin
      va = $random(seed);
      if (k == 0) ladr_i = va;
      else iadr_i = va;
      dacc_i = (k == 0);
      iacc_i = (k == 1);
      tick(HOLD);
      check_eq("padr_o", 64'(va), 64'(padr_o));
      check_eq("acr_o", 64'hF, 64'(acr_o));
      check_eq("tlbmiss_o", 64'd0, 64'(tlbmiss_o));
      iacc_i = 1'b0;
      dacc_i = 1'b0;
    end
    for (int k = 1; k <= 3; k++) begin
      next_i = 1'b1;
      tick(1);
      next_i = 1'b0;
      tick(2);                            // no strobe, padr holds
      pa = va + 32'(32 * k);
      check_eq("padr_o", 64'(pa), 64'(padr_o));
    end

    // accessed/dirty write-back, dirty follows we
    for (int k = 0; k < 2; k++) begin
      set_xlat(1'b1);
      ent   = random_entry(10'(200 + k), 8'h41 + 8'(k), 1'b0);
      ent.a = 1'b0;
      ent.d = 1'b0;
      sw_write(2'(k + 1), 10'(500 + 100 * k), 1'b0, ent);
      lookup({ent.vpn, 10'(500 + 100 * k), 12'h0AC}, ent.asid, 1'b0, k == 0);
      set_xlat(1'b0);
      sw_read(2'(k + 1), 10'(500 + 100 * k), ent);
      check_eq("a bit", 64'd1, 64'(ent.a));
      check_eq("d bit", 64'(k == 0), 64'(ent.d));
      read_check(2'(k + 1), 10'(500 + 100 * k));
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: files.f
tlb_pkg.sv
tlb_ram.sv
tlb_boot_fill.sv
tlb_sw_port.sv
tlb_lookup.sv
tlb.sv
tb_clk_gen.sv
tb_tlb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_tlb
RTL_TOP   := tlb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

SRCS      := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter-out tb_%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
